// ==== radio_pkg.sv ====
// shared types and default register map for the radio core, one channel per board, at most four boards
package radio_pkg;

   // ------------------------------------------------------------
   // types
   // ------------------------------------------------------------
   typedef logic [31:0] sample_t;    // i in the upper half, q in the lower half
   typedef logic [7:0]  set_addr_t;
   typedef logic [31:0] set_data_t;
   typedef logic [1:0]  db_idx_t;    // board select
   typedef logic [2:0]  fe_ctrl_t;
   typedef logic [2:0]  led_t;       // {rx, txrx_tx, txrx_rx}

   // front-end control bits
   localparam int FE_SWAP  = 0;
   localparam int FE_NEG_I = 1;
   localparam int FE_NEG_Q = 2;

   // ------------------------------------------------------------
   // default register map
   // ------------------------------------------------------------
   localparam set_addr_t SR_DB_BASE_DEF  = 8'd160;
   localparam set_addr_t SR_TX_FE_DEF    = 8'd208;
   localparam set_addr_t SR_RX_FE_DEF    = 8'd224;
   localparam set_addr_t RB_DB_BASE_DEF  = 8'd16;
   localparam int        NUM_DBOARDS_DEF = 2;

   // settings offsets from the board base
   localparam set_addr_t SR_OFF_GPIO_OUT = 8'd0;
   localparam set_addr_t SR_OFF_GPIO_DDR = 8'd1;
   localparam set_addr_t SR_OFF_MISC_OUT = 8'd2;
   localparam set_addr_t SR_OFF_LEDS     = 8'd3;  // low 3 bits only

   // readback offsets from the readback base
   localparam set_addr_t RB_OFF_MISC_IN  = 8'd0;
   localparam set_addr_t RB_OFF_GPIO_IN  = 8'd1;
   localparam set_addr_t RB_OFF_GPIO_OUT = 8'd2;
   localparam set_addr_t RB_OFF_GPIO_DDR = 8'd3;

endpackage

// ==== settings_router.sv ====
// board indices at or above NUM_DBOARDS are dropped and address and data hold until the next strobe
`timescale 1ns/1ps

module settings_router #(
   parameter int NUM_DBOARDS = radio_pkg::NUM_DBOARDS_DEF
) (
   input  logic                   radio_clk,
   input  logic                   i_rst_n,
   // settings request
   input  logic                   i_set_stb,
   input  radio_pkg::db_idx_t     i_set_db,
   input  radio_pkg::set_addr_t   i_set_addr,
   input  radio_pkg::set_data_t   i_set_data,
   // readback request
   input  logic                   i_rb_stb,
   input  radio_pkg::db_idx_t     i_rb_db,
   input  radio_pkg::set_addr_t   i_rb_addr,
   // to the boards
   output logic [NUM_DBOARDS-1:0] o_set_stb,
   output radio_pkg::set_addr_t   o_set_addr,
   output radio_pkg::set_data_t   o_set_data,
   output logic [NUM_DBOARDS-1:0] o_rb_stb,
   output radio_pkg::set_addr_t   o_rb_addr
);

   // ------------------------------------------------------------
   // one-hot strobe decode
   // ------------------------------------------------------------
   always_ff @(posedge radio_clk) begin
      if (!i_rst_n) begin
         o_set_stb <= '0;
         o_rb_stb  <= '0;
      end else begin
         for (int b = 0; b < NUM_DBOARDS; b++) begin
            o_set_stb[b] <= i_set_stb && (i_set_db == radio_pkg::db_idx_t'(b));
            o_rb_stb[b]  <= i_rb_stb && (i_rb_db == radio_pkg::db_idx_t'(b));
         end
      end
   end

   // shared address and data to every board
   always_ff @(posedge radio_clk) begin
      if (i_set_stb) begin
         o_set_addr <= i_set_addr;
         o_set_data <= i_set_data;
      end
      if (i_rb_stb) begin
         o_rb_addr <= i_rb_addr;  // reads may come back to back
      end
   end

   // only one board may see a given request
   a_set_onehot: assert property (@(posedge radio_clk) disable iff (!i_rst_n)
      $onehot0(o_set_stb));
   a_rb_onehot: assert property (@(posedge radio_clk) disable iff (!i_rst_n)
      $onehot0(o_rb_stb));

endmodule

// ==== db_frontend.sv ====
// one board with one rx and one tx channel and no tx strobe since tx samples are continuous
`timescale 1ns/1ps

module db_frontend #(
   parameter radio_pkg::set_addr_t SR_DB_BASE = radio_pkg::SR_DB_BASE_DEF,
   parameter radio_pkg::set_addr_t SR_TX_FE   = radio_pkg::SR_TX_FE_DEF,
   parameter radio_pkg::set_addr_t SR_RX_FE   = radio_pkg::SR_RX_FE_DEF,
   parameter radio_pkg::set_addr_t RB_DB_BASE = radio_pkg::RB_DB_BASE_DEF
) (
   input  logic                 radio_clk,
   input  logic                 i_rst_n,
   // settings and readback
   input  logic                 i_set_stb,
   input  radio_pkg::set_addr_t i_set_addr,
   input  radio_pkg::set_data_t i_set_data,
   input  logic                 i_rb_stb,
   input  radio_pkg::set_addr_t i_rb_addr,
   output logic                 o_rb_stb,
   output radio_pkg::set_data_t o_rb_data,
   // pins
   input  radio_pkg::set_data_t i_misc_in,
   input  radio_pkg::set_data_t i_db_gpio_in,
   output radio_pkg::set_data_t o_misc_out,
   output radio_pkg::set_data_t o_db_gpio_out,
   output radio_pkg::set_data_t o_db_gpio_ddr,
   output radio_pkg::led_t      o_led,
   // samples
   input  radio_pkg::sample_t   i_rx,
   input  logic                 i_rx_stb,
   input  radio_pkg::sample_t   i_tx,
   output radio_pkg::sample_t   o_rx,
   output logic                 o_rx_stb,
   output radio_pkg::sample_t   o_tx
);

   // absolute addresses of this board's registers
   localparam radio_pkg::set_addr_t A_GPIO_OUT = SR_DB_BASE + radio_pkg::SR_OFF_GPIO_OUT;
   localparam radio_pkg::set_addr_t A_GPIO_DDR = SR_DB_BASE + radio_pkg::SR_OFF_GPIO_DDR;
   localparam radio_pkg::set_addr_t A_MISC_OUT = SR_DB_BASE + radio_pkg::SR_OFF_MISC_OUT;
   localparam radio_pkg::set_addr_t A_LEDS     = SR_DB_BASE + radio_pkg::SR_OFF_LEDS;
   localparam radio_pkg::set_addr_t R_MISC_IN  = RB_DB_BASE + radio_pkg::RB_OFF_MISC_IN;
   localparam radio_pkg::set_addr_t R_GPIO_IN  = RB_DB_BASE + radio_pkg::RB_OFF_GPIO_IN;
   localparam radio_pkg::set_addr_t R_GPIO_OUT = RB_DB_BASE + radio_pkg::RB_OFF_GPIO_OUT;
   localparam radio_pkg::set_addr_t R_GPIO_DDR = RB_DB_BASE + radio_pkg::RB_OFF_GPIO_DDR;

   radio_pkg::fe_ctrl_t  rx_ctrl;
   radio_pkg::fe_ctrl_t  tx_ctrl;
   radio_pkg::set_data_t misc_in_r;
   radio_pkg::set_data_t gpio_in_r;

   // swap first, then negate each half on its own
   function automatic radio_pkg::sample_t fe_correct(input radio_pkg::sample_t s,
                                                     input radio_pkg::fe_ctrl_t ctrl);
      logic [15:0] i_part;
      logic [15:0] q_part;
      i_part = ctrl[radio_pkg::FE_SWAP] ? s[15:0] : s[31:16];
      q_part = ctrl[radio_pkg::FE_SWAP] ? s[31:16] : s[15:0];
      if (ctrl[radio_pkg::FE_NEG_I]) i_part = -i_part;  // -32768 wraps to itself
      if (ctrl[radio_pkg::FE_NEG_Q]) q_part = -q_part;
      return {i_part, q_part};
   endfunction

   // ------------------------------------------------------------
   // control registers
   // ------------------------------------------------------------
   always_ff @(posedge radio_clk) begin
      if (!i_rst_n) begin
         o_db_gpio_out <= '0;
         o_db_gpio_ddr <= '0;
         o_misc_out    <= '0;
         o_led         <= '0;
         rx_ctrl       <= '0;
         tx_ctrl       <= '0;
      end else if (i_set_stb) begin
         case (i_set_addr)
            A_GPIO_OUT: o_db_gpio_out <= i_set_data;
            A_GPIO_DDR: o_db_gpio_ddr <= i_set_data;
            A_MISC_OUT: o_misc_out    <= i_set_data;
            A_LEDS:     o_led         <= i_set_data[2:0];
            SR_TX_FE:   tx_ctrl       <= i_set_data[2:0];
            SR_RX_FE:   rx_ctrl       <= i_set_data[2:0];
            default: ;  // not ours
         endcase
      end
   end

   // pin inputs sampled once before readback
   always_ff @(posedge radio_clk) begin
      misc_in_r <= i_misc_in;
      gpio_in_r <= i_db_gpio_in;
   end

   // ------------------------------------------------------------
   // readback
   // ------------------------------------------------------------
   always_ff @(posedge radio_clk) begin
      if (!i_rst_n) begin
         o_rb_stb  <= 1'b0;
         o_rb_data <= '0;
      end else begin
         o_rb_stb <= i_rb_stb;
         if (i_rb_stb) begin
            case (i_rb_addr)
               R_MISC_IN:  o_rb_data <= misc_in_r;
               R_GPIO_IN:  o_rb_data <= gpio_in_r;
               R_GPIO_OUT: o_rb_data <= o_db_gpio_out;
               R_GPIO_DDR: o_rb_data <= o_db_gpio_ddr;
               default:    o_rb_data <= '0;
            endcase
         end
      end
   end

   // ------------------------------------------------------------
   // rx and tx front ends
   // ------------------------------------------------------------
   always_ff @(posedge radio_clk) begin
      if (!i_rst_n) begin
         o_rx     <= '0;
         o_rx_stb <= 1'b0;
         o_tx     <= '0;
      end else begin
         o_rx_stb <= i_rx_stb;
         if (i_rx_stb) o_rx <= fe_correct(i_rx, rx_ctrl);  // hold between strobes
         o_tx <= fe_correct(i_tx, tx_ctrl);
      end
   end

   // the router and mux count on exactly one answer per request
   a_rb_answer: assert property (@(posedge radio_clk) disable iff (!i_rst_n)
      i_rb_stb |=> o_rb_stb);
   a_rb_no_extra: assert property (@(posedge radio_clk) disable iff (!i_rst_n)
      o_rb_stb |-> $past(i_rb_stb));

endmodule

// ==== readback_mux.sv ====
// expects at most one board to answer per cycle and keeps the last data when idle
`timescale 1ns/1ps

module readback_mux #(
   parameter int NUM_DBOARDS = radio_pkg::NUM_DBOARDS_DEF
) (
   input  logic                                     radio_clk,
   input  logic                                     i_rst_n,
   input  logic [NUM_DBOARDS-1:0]                   i_rb_stb,
   input  radio_pkg::set_data_t [NUM_DBOARDS-1:0]   i_rb_data,
   output logic                                     o_rb_stb,
   output radio_pkg::set_data_t                     o_rb_data
);

   radio_pkg::set_data_t sel_data;

   // and-or select of the active response
   always_comb begin
      sel_data = '0;
      for (int b = 0; b < NUM_DBOARDS; b++) begin
         sel_data = sel_data | (i_rb_data[b] & {32{i_rb_stb[b]}});
      end
   end

   // ------------------------------------------------------------
   // output register
   // ------------------------------------------------------------
   always_ff @(posedge radio_clk) begin
      if (!i_rst_n) begin
         o_rb_stb  <= 1'b0;
         o_rb_data <= '0;
      end else begin
         o_rb_stb <= |i_rb_stb;
         if (|i_rb_stb) begin
            o_rb_data <= sel_data;
         end
      end
   end

   // two boards answering at once would merge their data
   a_one_responder: assert property (@(posedge radio_clk) disable iff (!i_rst_n)
      $onehot0(i_rb_stb));

endmodule

// ==== radio_core.sv ====
// radio core top with NUM_DBOARDS from 1 to 4 and one rx and one tx channel per board
`timescale 1ns/1ps

module radio_core #(
   parameter int                   NUM_DBOARDS = radio_pkg::NUM_DBOARDS_DEF,
   parameter radio_pkg::set_addr_t SR_DB_BASE  = radio_pkg::SR_DB_BASE_DEF,
   parameter radio_pkg::set_addr_t SR_TX_FE    = radio_pkg::SR_TX_FE_DEF,
   parameter radio_pkg::set_addr_t SR_RX_FE    = radio_pkg::SR_RX_FE_DEF,
   parameter radio_pkg::set_addr_t RB_DB_BASE  = radio_pkg::RB_DB_BASE_DEF
) (
   input  logic                                   radio_clk,
   input  logic                                   i_rst_n,
   // settings bus
   input  logic                                   i_set_stb,
   input  radio_pkg::db_idx_t                     i_set_db,
   input  radio_pkg::set_addr_t                   i_set_addr,
   input  radio_pkg::set_data_t                   i_set_data,
   // readback bus
   input  logic                                   i_rb_stb,
   input  radio_pkg::db_idx_t                     i_rb_db,
   input  radio_pkg::set_addr_t                   i_rb_addr,
   output logic                                   o_rb_stb,
   output radio_pkg::set_data_t                   o_rb_data,
   // per-board samples
   input  radio_pkg::sample_t   [NUM_DBOARDS-1:0] i_rx,
   input  logic                 [NUM_DBOARDS-1:0] i_rx_stb,
   output radio_pkg::sample_t   [NUM_DBOARDS-1:0] o_rx,
   output logic                 [NUM_DBOARDS-1:0] o_rx_stb,
   input  radio_pkg::sample_t   [NUM_DBOARDS-1:0] i_tx,
   output radio_pkg::sample_t   [NUM_DBOARDS-1:0] o_tx,
   // per-board pins
   input  radio_pkg::set_data_t [NUM_DBOARDS-1:0] i_misc_in,
   output radio_pkg::set_data_t [NUM_DBOARDS-1:0] o_misc_out,
   input  radio_pkg::set_data_t [NUM_DBOARDS-1:0] i_db_gpio_in,
   output radio_pkg::set_data_t [NUM_DBOARDS-1:0] o_db_gpio_out,
   output radio_pkg::set_data_t [NUM_DBOARDS-1:0] o_db_gpio_ddr,
   output radio_pkg::led_t      [NUM_DBOARDS-1:0] o_radio_led
);

   logic                 [NUM_DBOARDS-1:0] set_stb;
   radio_pkg::set_addr_t                   set_addr;
   radio_pkg::set_data_t                   set_data;
   logic                 [NUM_DBOARDS-1:0] rb_req_stb;
   radio_pkg::set_addr_t                   rb_addr;
   logic                 [NUM_DBOARDS-1:0] rb_resp_stb;
   radio_pkg::set_data_t [NUM_DBOARDS-1:0] rb_resp_data;

   // ------------------------------------------------------------
   // request routing
   // ------------------------------------------------------------
   settings_router #(.NUM_DBOARDS(NUM_DBOARDS)) settings_router_i (
      .radio_clk  (radio_clk),
      .i_rst_n    (i_rst_n),
      .i_set_stb  (i_set_stb),
      .i_set_db   (i_set_db),
      .i_set_addr (i_set_addr),
      .i_set_data (i_set_data),
      .i_rb_stb   (i_rb_stb),
      .i_rb_db    (i_rb_db),
      .i_rb_addr  (i_rb_addr),
      .o_set_stb  (set_stb),
      .o_set_addr (set_addr),
      .o_set_data (set_data),
      .o_rb_stb   (rb_req_stb),
      .o_rb_addr  (rb_addr)
   );

   // ------------------------------------------------------------
   // daughterboards
   // ------------------------------------------------------------
   for (genvar g = 0; g < NUM_DBOARDS; g++) begin : gen_db
      db_frontend #(
         .SR_DB_BASE (SR_DB_BASE),
         .SR_TX_FE   (SR_TX_FE),
         .SR_RX_FE   (SR_RX_FE),
         .RB_DB_BASE (RB_DB_BASE)
      ) db_frontend_i (
         .radio_clk     (radio_clk),
         .i_rst_n       (i_rst_n),
         .i_set_stb     (set_stb[g]),
         .i_set_addr    (set_addr),
         .i_set_data    (set_data),
         .i_rb_stb      (rb_req_stb[g]),
         .i_rb_addr     (rb_addr),
         .o_rb_stb      (rb_resp_stb[g]),
         .o_rb_data     (rb_resp_data[g]),
         .i_misc_in     (i_misc_in[g]),
         .i_db_gpio_in  (i_db_gpio_in[g]),
         .o_misc_out    (o_misc_out[g]),
         .o_db_gpio_out (o_db_gpio_out[g]),
         .o_db_gpio_ddr (o_db_gpio_ddr[g]),
         .o_led         (o_radio_led[g]),
         .i_rx          (i_rx[g]),
         .i_rx_stb      (i_rx_stb[g]),
         .i_tx          (i_tx[g]),
         .o_rx          (o_rx[g]),
         .o_rx_stb      (o_rx_stb[g]),
         .o_tx          (o_tx[g])
      );
   end

   // responses back onto the single readback port
   readback_mux #(.NUM_DBOARDS(NUM_DBOARDS)) readback_mux_i (
      .radio_clk (radio_clk),
      .i_rst_n   (i_rst_n),
      .i_rb_stb  (rb_resp_stb),
      .i_rb_data (rb_resp_data),
      .o_rb_stb  (o_rb_stb),
      .o_rb_data (o_rb_data)
   );

endmodule

// ==== tb_clkgen.sv ====
// free-running clock from time zero, reset released on a falling edge after RST_CYCLES rising edges
`timescale 1ns/1ps

module tb_clkgen #(
   parameter int PERIOD_NS  = 100,
   parameter int RST_CYCLES = 4
) (
   output logic o_clk,
   output logic o_rst_n
);

   initial begin
      o_clk = 1'b0;
      forever #(PERIOD_NS / 2) o_clk = ~o_clk;
   end

   initial begin
      o_rst_n = 1'b0;
      repeat (RST_CYCLES) @(posedge o_clk);
      @(negedge o_clk);  // release away from the sampling edge
      o_rst_n = 1'b1;
   end

endmodule

// ==== tb_radio_core.sv ====
// two boards on the default register map, readback checked in order at a latency of exactly 3
`timescale 1ns/1ps

module tb_radio_core;

   localparam int NDB = 2;

   typedef enum logic [2:0] {K_RESET, K_IDLE, K_WRITE, K_READ, K_RX, K_TX} kind_e;
   typedef struct {
      kind_e                kind;
      int                   board;
      radio_pkg::set_addr_t addr;
      radio_pkg::set_data_t data;
      radio_pkg::set_data_t exp;
   } row_t;

   logic                                   radio_clk;
   logic                                   rst_n;
   logic                                   set_stb;
   radio_pkg::db_idx_t                     set_db;
   radio_pkg::set_addr_t                   set_addr;
   radio_pkg::set_data_t                   set_data;
   logic                                   rb_stb;
   radio_pkg::db_idx_t                     rb_db;
   radio_pkg::set_addr_t                   rb_addr;
   logic                                   rb_stb_out;
   radio_pkg::set_data_t                   rb_data_out;
   radio_pkg::sample_t   [NDB-1:0]         rx_in;
   logic                 [NDB-1:0]         rx_stb_in;
   radio_pkg::sample_t   [NDB-1:0]         rx_out;
   logic                 [NDB-1:0]         rx_stb_out;
   radio_pkg::sample_t   [NDB-1:0]         tx_in;
   radio_pkg::sample_t   [NDB-1:0]         tx_out;
   radio_pkg::set_data_t [NDB-1:0]         misc_in;
   radio_pkg::set_data_t [NDB-1:0]         misc_out;
   radio_pkg::set_data_t [NDB-1:0]         gpio_in;
   radio_pkg::set_data_t [NDB-1:0]         gpio_out;
   radio_pkg::set_data_t [NDB-1:0]         gpio_ddr;
   radio_pkg::led_t      [NDB-1:0]         led;

   row_t                 tbl[$];
   int                   rb_due[$];      // cycle at which each read must answer
   radio_pkg::set_data_t rb_exp[$];
   int                   cyc = 0;
   int                   cycle_limit = 0;
   radio_pkg::set_data_t m_gpio_out[NDB];
   radio_pkg::set_data_t m_gpio_ddr[NDB];

   tb_clkgen #(.PERIOD_NS(100), .RST_CYCLES(4)) clkgen0 (
      .o_clk   (radio_clk),
      .o_rst_n (rst_n)
   );

   radio_core #(.NUM_DBOARDS(NDB)) dut0 (
      .radio_clk     (radio_clk),
      .i_rst_n       (rst_n),
      .i_set_stb     (set_stb),
      .i_set_db      (set_db),
      .i_set_addr    (set_addr),
      .i_set_data    (set_data),
      .i_rb_stb      (rb_stb),
      .i_rb_db       (rb_db),
      .i_rb_addr     (rb_addr),
      .o_rb_stb      (rb_stb_out),
      .o_rb_data     (rb_data_out),
      .i_rx          (rx_in),
      .i_rx_stb      (rx_stb_in),
      .o_rx          (rx_out),
      .o_rx_stb      (rx_stb_out),
      .i_tx          (tx_in),
      .o_tx          (tx_out),
      .i_misc_in     (misc_in),
      .o_misc_out    (misc_out),
      .i_db_gpio_in  (gpio_in),
      .o_db_gpio_out (gpio_out),
      .o_db_gpio_ddr (gpio_ddr),
      .o_radio_led   (led)
   );

   // ------------------------------------------------------------
   // error handling and compare tasks
   // ------------------------------------------------------------
   task automatic abort_run();
      $display("Simulation FAILED");
      $fatal(1);
   endtask

   task automatic fail_with_reason(input string what);
      $display("ERROR: %s (cycle %0d)", what, cyc);
      abort_run();
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
         abort_run();
      end
   endtask

   task automatic check_data(input string name, input radio_pkg::set_data_t got,
                             input radio_pkg::set_data_t exp);
      if (got !== exp) begin
         $display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
         abort_run();
      end
   endtask

   task automatic check_sample(input string name, input radio_pkg::sample_t got,
                               input radio_pkg::sample_t exp);
      if (got !== exp) begin
         $display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
         abort_run();
      end
   endtask

   task automatic check_led(input string name, input radio_pkg::led_t got,
                            input radio_pkg::led_t exp);
      if (got !== exp) begin
         $display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
         abort_run();
      end
   endtask

   // swap on bit 0, then negate i on bit 1 and q on bit 2 with wrap
   function automatic radio_pkg::sample_t fe_expect(input radio_pkg::sample_t s,
                                                    input radio_pkg::fe_ctrl_t c);
      logic [15:0] re;
      logic [15:0] im;
      re = s[31:16];
      im = s[15:0];
      if (c[0]) begin
         re = s[15:0];
         im = s[31:16];
      end
      if (c[1]) re = ~re + 16'd1;
      if (c[2]) im = ~im + 16'd1;
      return {re, im};
   endfunction

   // ------------------------------------------------------------
   // stimulus table
   // ------------------------------------------------------------
   task automatic add_row(input kind_e k, input int b, input radio_pkg::set_addr_t a,
                          input radio_pkg::set_data_t d, input radio_pkg::set_data_t e);
      row_t r;
      r.kind  = k;
      r.board = b;
      r.addr  = a;
      r.data  = d;
      r.exp   = e;
      tbl.push_back(r);
   endtask

   task automatic build_table();
      radio_pkg::set_data_t d;
      radio_pkg::sample_t   s;
      radio_pkg::fe_ctrl_t  c0;
      radio_pkg::fe_ctrl_t  c1;
      add_row(K_RESET, 0, '0, '0, '0);
      for (int b = 0; b < NDB; b++) begin
         for (int off = 0; off < 4; off++) begin
            d = $urandom();
            add_row(K_WRITE, b, radio_pkg::SR_DB_BASE_DEF + radio_pkg::set_addr_t'(off), d,
                    (off == 3) ? {29'd0, d[2:0]} : d);  // leds keep 3 bits
            if (off == 0) m_gpio_out[b] = d;
            if (off == 1) m_gpio_ddr[b] = d;
         end
      end
      // board 0 back to back, board 1 one at a time
      for (int b = 0; b < NDB; b++) begin
         for (int off = 0; off < 5; off++) begin
            case (off)
               0:       d = misc_in[b];
               1:       d = gpio_in[b];
               2:       d = m_gpio_out[b];
               3:       d = m_gpio_ddr[b];
               default: d = '0;  // unlisted address
            endcase
            add_row(K_READ, b, radio_pkg::RB_DB_BASE_DEF + radio_pkg::set_addr_t'(off), '0, d);
            if (b == 1) add_row(K_IDLE, b, '0, '0, '0);
         end
      end
      for (int c = 0; c < 8; c++) begin
         add_row(K_WRITE, 0, radio_pkg::SR_RX_FE_DEF, 32'(c), 32'(c));
         s = $urandom();
         add_row(K_RX, 0, '0, s, fe_expect(s, radio_pkg::fe_ctrl_t'(c)));
         s = (c % 2 == 1) ? {16'h8000, s[15:0]} : {s[31:16], 16'h8000};  // most negative
         add_row(K_RX, 0, '0, s, fe_expect(s, radio_pkg::fe_ctrl_t'(c)));
      end
      s = $urandom();
      add_row(K_RX, 1, '0, s, s);  // board 1 rx control still zero
      for (int k = 0; k < 4; k++) begin
         c0 = radio_pkg::fe_ctrl_t'(2 * k + 1);
         c1 = radio_pkg::fe_ctrl_t'(6 - 2 * k);
         add_row(K_WRITE, 0, radio_pkg::SR_TX_FE_DEF, {29'd0, c0}, {29'd0, c0});
         add_row(K_WRITE, 1, radio_pkg::SR_TX_FE_DEF, {29'd0, c1}, {29'd0, c1});
         s = $urandom();
         add_row(K_TX, 0, '0, s, fe_expect(s, c0));
         add_row(K_TX, 1, '0, s, fe_expect(s, c1));
      end
   endtask

   task automatic check_reset_state();
      check_bit("o_rb_stb", rb_stb_out, 1'b0);
      check_data("o_rb_data", rb_data_out, '0);
      for (int b = 0; b < NDB; b++) begin
         check_bit("o_rx_stb", rx_stb_out[b], 1'b0);
         check_sample("o_rx", rx_out[b], '0);
         check_sample("o_tx", tx_out[b], '0);
         check_data("o_misc_out", misc_out[b], '0);
         check_data("o_db_gpio_out", gpio_out[b], '0);
         check_data("o_db_gpio_ddr", gpio_ddr[b], '0);
         check_led("o_radio_led", led[b], '0);
      end
   endtask

   task automatic apply_row(input row_t r, input bit next_is_read);
      int                   o;
      radio_pkg::set_data_t snap_out;
      radio_pkg::set_data_t snap_ddr;
      radio_pkg::set_data_t snap_misc;
      radio_pkg::led_t      snap_led;
      o = (r.board + 1) % NDB;
      @(negedge radio_clk);
      case (r.kind)
         K_RESET: check_reset_state();
         K_WRITE: begin
            snap_out  = gpio_out[o];
            snap_ddr  = gpio_ddr[o];
            snap_misc = misc_out[o];
            snap_led  = led[o];
            set_stb   = 1'b1;
            set_db    = radio_pkg::db_idx_t'(r.board);
            set_addr  = r.addr;
            set_data  = r.data;
            @(negedge radio_clk);
            set_stb = 1'b0;
            @(negedge radio_clk);  // two cycles to the pins
            case (r.addr)
               radio_pkg::SR_DB_BASE_DEF + radio_pkg::SR_OFF_GPIO_OUT:
                  check_data("o_db_gpio_out", gpio_out[r.board], r.exp);
               radio_pkg::SR_DB_BASE_DEF + radio_pkg::SR_OFF_GPIO_DDR:
                  check_data("o_db_gpio_ddr", gpio_ddr[r.board], r.exp);
               radio_pkg::SR_DB_BASE_DEF + radio_pkg::SR_OFF_MISC_OUT:
                  check_data("o_misc_out", misc_out[r.board], r.exp);
               radio_pkg::SR_DB_BASE_DEF + radio_pkg::SR_OFF_LEDS:
                  check_led("o_radio_led", led[r.board], r.exp[2:0]);
               default: ;  // front-end controls show up on samples
            endcase
            check_data("o_db_gpio_out other board", gpio_out[o], snap_out);
            check_data("o_db_gpio_ddr other board", gpio_ddr[o], snap_ddr);
            check_data("o_misc_out other board", misc_out[o], snap_misc);
            check_led("o_radio_led other board", led[o], snap_led);
         end
         K_READ: begin
            rb_stb  = 1'b1;
            rb_db   = radio_pkg::db_idx_t'(r.board);
            rb_addr = r.addr;
            rb_due.push_back(cyc + 3);
            rb_exp.push_back(r.exp);
            if (!next_is_read) begin
               @(negedge radio_clk);
               rb_stb = 1'b0;
               while (rb_due.size() != 0) @(negedge radio_clk);
            end
         end
         K_RX: begin
            check_bit("o_rx_stb before strobe", rx_stb_out[r.board], 1'b0);
            rx_in[r.board]     = r.data;
            rx_stb_in[r.board] = 1'b1;
            @(negedge radio_clk);
            rx_stb_in[r.board] = 1'b0;
            check_bit("o_rx_stb", rx_stb_out[r.board], 1'b1);
            check_sample("o_rx", rx_out[r.board], r.exp);
         end
         K_TX: begin
            for (int b = 0; b < NDB; b++) tx_in[b] = r.data;
            @(negedge radio_clk);
            check_sample("o_tx", tx_out[r.board], r.exp);
         end
         default: ;  // idle cycle
      endcase
   endtask

   // ------------------------------------------------------------
   // readback monitor, timeout and main sequence
   // ------------------------------------------------------------
   always @(negedge radio_clk) begin
      if (rst_n) begin
         if (rb_stb_out) begin
            if (rb_due.size() == 0) begin
               fail_with_reason("readback strobe without a pending request");
            end else if (cyc != rb_due[0]) begin
               fail_with_reason("readback answered at the wrong cycle");
            end else begin
               check_data("o_rb_data", rb_data_out, rb_exp[0]);
               void'(rb_due.pop_front());
               void'(rb_exp.pop_front());
            end
         end else if (rb_due.size() != 0 && cyc >= rb_due[0]) begin
            fail_with_reason("readback response missing");
         end
      end
   end

   always @(posedge radio_clk) begin
      cyc <= cyc + 1;
      if (cycle_limit != 0 && cyc > cycle_limit) begin
         $display("ERROR: timeout after %0d cycles before the table was done", cyc);
         $display("Simulation FAILED");
         $fatal(1);
      end
   end

   initial begin
      int seed_ret;
      seed_ret  = $urandom(96);
      set_stb   = 1'b0;
      set_db    = '0;
      set_addr  = '0;
      set_data  = '0;
      rb_stb    = 1'b0;
      rb_db     = '0;
      rb_addr   = '0;
      rx_in     = '0;
      rx_stb_in = '0;
      tx_in     = '0;
      for (int b = 0; b < NDB; b++) begin
         misc_in[b] = $urandom();
         gpio_in[b] = $urandom();
      end
      build_table();
      cycle_limit = tbl.size() * 8 + 50;
      @(posedge rst_n);
      for (int i = 0; i < tbl.size(); i++) begin
         apply_row(tbl[i], (i + 1 < tbl.size()) && (tbl[i + 1].kind == K_READ));
      end
      repeat (2) @(negedge radio_clk);
      if (rb_due.size() == 0) begin
         $display("Simulation PASSED");
         $finish;
      end else begin
         fail_with_reason("readback responses still pending at the end");
      end
   end

endmodule

// ==== project.f ====
radio_pkg.sv
settings_router.sv
db_frontend.sv
readback_mux.sv
radio_core.sv
tb_clkgen.sv
tb_radio_core.sv

// ==== Makefile ====
# Verilator build and run of the radio core testbench

VERILATOR ?= verilator
TOP       ?= tb_radio_core
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_STR  ?= Simulation PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the result is decided by the pass line in the output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_STR)"

clean:
	rm -rf $(OBJ_DIR)
